/* design/n64_glue_pkg.sv */
// n64 glue package: loader stream, download word, ram and pif ports, video config types
package n64_glue_pkg;

	// ====================
	// widths and codes
	// ====================

	// byte address width of the cartridge ram channel
	localparam int RAM_ADDR_W = 27;

	// host file index, compared on bits 5..0 only
	// bit 6 selects the upper pif rom half
	localparam logic [5:0] INDEX_PIF      = 6'd0;
	localparam logic [5:0] INDEX_CART_N64 = 6'd1;
	localparam logic [5:0] INDEX_CART_GB  = 6'd2;

	// ====================
	// host and memory ports
	// ====================

	// host loader stream, 16 bit halfwords
	typedef struct packed {
		logic                  download;
		logic [7:0]            index;
		logic [RAM_ADDR_W-1:0] addr;
		logic [15:0]           dout;
		logic                  wr;
	} ioctl_req_t;

	// download word, halfword view for the cart
	typedef struct packed {
		logic [15:0] hi;
		logic [15:0] lo;
	} half_pair_t;

	// download word, byte view for the pif rom
	typedef struct packed {
		logic [7:0] b3;
		logic [7:0] b2;
		logic [7:0] b1;
		logic [7:0] b0;
	} byte_quad_t;

	typedef union packed {
		half_pair_t halves;
		byte_quad_t bytes;
	} download_word_u;

	// single word write to external ram
	typedef struct packed {
		logic                  req;
		logic [RAM_ADDR_W-1:0] addr;
		logic [31:0]           data;
	} ram_wr_t;

	// pif rom write port, 1k words
	typedef struct packed {
		logic        en;
		logic [9:0]  addr;
		logic [31:0] data;
	} pif_wr_t;

	// ====================
	// video
	// ====================

	typedef struct packed {
		logic       is_pal;
		logic       blanks_off;
		logic [1:0] crop;
		logic [1:0] ar_mode;
	} video_cfg_t;

	// hdmi aspect ratio, x over y
	typedef struct packed {
		logic [12:0] arx;
		logic [12:0] ary;
	} aspect_t;

endpackage

/* design/pif_rom_loader.sv */
// pif rom loader: pairs host halfwords into byte-swapped boot rom words for the pif write port
`timescale 1ns/1ns

module pif_rom_loader (
	input  logic                    clk_1x,
	input  logic                    rst_n,
	input  n64_glue_pkg::ioctl_req_t ioctl,
	output n64_glue_pkg::pif_wr_t    pif_wr
);

	// active flag, one cycle behind download
	logic                         pif_active;
	logic                         en_q;
	logic [9:0]                   addr_q;
	n64_glue_pkg::download_word_u word_q;

	// ====================
	// control
	// ====================
	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			pif_active <= 1'b0;
			en_q       <= 1'b0;
		end else begin
			pif_active <= ioctl.download && (ioctl.index[5:0] == n64_glue_pkg::INDEX_PIF);
			// one cycle strobe on the second half
			en_q       <= pif_active && ioctl.wr && ioctl.addr[1];
		end
	end

	// ====================
	// word assembly
	// ====================
	always_ff @(posedge clk_1x) begin
		if (pif_active && ioctl.wr) begin
			if (!ioctl.addr[1]) begin
				// first half, swapped into the top bytes
				word_q.bytes.b3 <= ioctl.dout[7:0];
				word_q.bytes.b2 <= ioctl.dout[15:8];
				// bit 6 of index picks the rom half
				addr_q          <= {ioctl.index[6], ioctl.addr[10:2]};
			end else begin
				word_q.bytes.b1 <= ioctl.dout[7:0];
				word_q.bytes.b0 <= ioctl.dout[15:8];
			end
		end
	end

	assign pif_wr.en   = en_q;
	assign pif_wr.addr = addr_q;
	assign pif_wr.data = word_q;

	// back to back second halves would mean a lost first half
	a_en_single: assert property (@(posedge clk_1x) disable iff (!rst_n)
		pif_wr.en |=> !pif_wr.en)
		else $error("pif write enable held for two cycles");

endmodule

/* design/cart_loader.sv */
// cartridge loader: pairs host halfwords into ram words at the n64 or gb base, stalls host on ram
`timescale 1ns/1ns

module cart_loader #(
	parameter logic [n64_glue_pkg::RAM_ADDR_W-1:0] CART_N64_BASE = 27'd16777216,
	parameter logic [n64_glue_pkg::RAM_ADDR_W-1:0] CART_GB_BASE  = 27'd8388608
) (
	input  logic                     clk_1x,
	input  logic                     rst_n,
	input  n64_glue_pkg::ioctl_req_t ioctl,
	input  logic                     ram_ready,
	output n64_glue_pkg::ram_wr_t    ram_wr,
	output logic                     ioctl_wait,
	output logic                     cart_loaded,
	output logic                     cart_busy
);

	// per type active flags, one cycle behind download
	logic n64_active;
	logic gb_active;
	logic cart_active;
	logic req_q;
	logic wait_q;
	logic loaded_q;

	// payload
	logic [n64_glue_pkg::RAM_ADDR_W-1:0] base;
	logic [n64_glue_pkg::RAM_ADDR_W-1:0] addr_q;
	n64_glue_pkg::download_word_u        word_q;

	assign cart_active = n64_active | gb_active;

	// gb only when the n64 flag is clear
	assign base = n64_active ? CART_N64_BASE : CART_GB_BASE;

	// ====================
	// control and handshake
	// ====================
	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			n64_active <= 1'b0;
			gb_active  <= 1'b0;
			req_q      <= 1'b0;
			wait_q     <= 1'b0;
			loaded_q   <= 1'b0;
		end else begin
			n64_active <= ioctl.download &&
				(ioctl.index[5:0] == n64_glue_pkg::INDEX_CART_N64);
			gb_active  <= ioctl.download &&
				(ioctl.index[5:0] == n64_glue_pkg::INDEX_CART_GB);
			req_q      <= 1'b0;
			// sticky until reset, gb does not count
			if (n64_active) begin
				loaded_q <= 1'b1;
			end
			if (cart_active) begin
				// word complete, request and hold the host off
				if (ioctl.wr && ioctl.addr[1]) begin
					req_q  <= 1'b1;
					wait_q <= 1'b1;
				end
				// ram took it, release next cycle
				if (ram_ready) begin
					wait_q <= 1'b0;
				end
			end else begin
				wait_q <= 1'b0;
			end
		end
	end

	// ====================
	// word assembly
	// ====================
	always_ff @(posedge clk_1x) begin
		if (cart_active && ioctl.wr) begin
			if (!ioctl.addr[1]) begin
				word_q.halves.lo <= ioctl.dout;
				addr_q           <= ioctl.addr + base;
			end else begin
				word_q.halves.hi <= ioctl.dout;
			end
		end
	end

	assign ram_wr.req  = req_q;
	assign ram_wr.addr = addr_q;
	assign ram_wr.data = word_q;
	assign ioctl_wait  = wait_q;
	assign cart_loaded = loaded_q;
	assign cart_busy   = cart_active;

	// every request opens a stall window
	a_req_wait: assert property (@(posedge clk_1x) disable iff (!rst_n)
		ram_wr.req |-> ioctl_wait)
		else $error("ram request without host wait");

	// host side must honour the stall
	a_no_wr_in_wait: assert property (@(posedge clk_1x) disable iff (!rst_n)
		ioctl_wait |-> !ioctl.wr)
		else $error("host write while wait is high");

endmodule

/* design/aspect_ratio_sel.sv */
// aspect ratio select: hdmi aspect from standard, crop, blank and aspect mode settings
`timescale 1ns/1ns

module aspect_ratio_sel (
	input  logic                     clk_1x,
	input  logic                     rst_n,
	input  n64_glue_pkg::video_cfg_t cfg,
	output n64_glue_pkg::aspect_t    aspect
);

	// core ratio, tracks the table even while a forced mode is shown
	n64_glue_pkg::aspect_t core_q;
	n64_glue_pkg::aspect_t core_next;

	// ====================
	// core ratio table
	// ====================
	always_comb begin
		// crop 3 keeps the last ratio
		core_next = core_q;
		if (cfg.blanks_off) begin
			core_next = '{arx: 13'd4, ary: 13'd3};
		end else if (cfg.is_pal) begin
			case (cfg.crop)
				2'd0: core_next = '{arx: 13'd512, ary: 13'd387};
				2'd1: core_next = '{arx: 13'd1024, ary: 13'd731};
				2'd2: core_next = '{arx: 13'd2048, ary: 13'd1419};
				default: core_next = core_q;
			endcase
		end else begin
			// ntsc
			case (cfg.crop)
				2'd0: core_next = '{arx: 13'd512, ary: 13'd381};
				2'd1: core_next = '{arx: 13'd1280, ary: 13'd889};
				2'd2: core_next = '{arx: 13'd2560, ary: 13'd1714};
				default: core_next = core_q;
			endcase
		end
	end

	// ====================
	// output register
	// ====================
	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			core_q <= '{arx: 13'd4, ary: 13'd3};
			aspect <= '{arx: 13'd4, ary: 13'd3};
		end else begin
			core_q <= core_next;
			// modes 1..3 pass a scaler code, y zero
			if (cfg.ar_mode != 2'd0) begin
				aspect.arx <= {11'd0, cfg.ar_mode - 2'd1};
				aspect.ary <= 13'd0;
			end else begin
				aspect <= core_next;
			end
		end
	end

endmodule

/* design/pad_port_mux.sv */
// pad port mux: routes the snac controller line to one of four user port pins
`timescale 1ns/1ns

module pad_port_mux (
	input  logic       clk_1x,
	input  logic       rst_n,
	input  logic       snac_en,
	input  logic [1:0] pad_index,
	input  logic       pad_tx,
	input  logic [6:0] user_in,
	output logic [6:0] user_out,
	output logic       pad_rx
);

	logic [2:0] pin_sel;
	logic [6:0] out_next;

	// pad to pin map, d- d+ rx- rx+
	always_comb begin
		case (pad_index)
			2'd0: pin_sel = 3'd1;
			2'd1: pin_sel = 3'd0;
			2'd2: pin_sel = 3'd5;
			default: pin_sel = 3'd4;
		endcase
	end

	// open drain, 1 releases the pin
	// unselected pads released too, so 2, 3 and 6 stay high
	always_comb begin
		out_next          = 7'h7f;
		out_next[pin_sel] = pad_tx;
	end

	// ====================
	// registered pins
	// ====================
	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			user_out <= 7'h7f;
			pad_rx   <= 1'b1;
		end else if (snac_en) begin
			user_out <= out_next;
			pad_rx   <= user_in[pin_sel];
		end else begin
			// snac off, rx keeps its last sample
			user_out <= 7'h7f;
		end
	end

endmodule

/* design/n64_glue_top.sv */
// n64 glue top: loader, aspect and controller port blocks on the core clock
`timescale 1ns/1ns

module n64_glue_top #(
	parameter logic [n64_glue_pkg::RAM_ADDR_W-1:0] CART_N64_BASE = 27'd16777216,
	parameter logic [n64_glue_pkg::RAM_ADDR_W-1:0] CART_GB_BASE  = 27'd8388608
) (
	input  logic                     clk_1x,
	input  logic                     rst_n,
	// host loader
	input  n64_glue_pkg::ioctl_req_t ioctl,
	input  logic                     ram_ready,
	output n64_glue_pkg::ram_wr_t    ram_wr,
	output logic                     ioctl_wait,
	output logic                     cart_loaded,
	output logic                     cart_busy,
	output n64_glue_pkg::pif_wr_t    pif_wr,
	// video
	input  n64_glue_pkg::video_cfg_t video_cfg,
	output n64_glue_pkg::aspect_t    aspect,
	// controller port
	input  logic                     snac_en,
	input  logic [1:0]               pad_index,
	input  logic                     pad_tx,
	input  logic [6:0]               user_in,
	output logic [6:0]               user_out,
	output logic                     pad_rx
);

	// ====================
	// download
	// ====================
	pif_rom_loader u_pif_rom_loader (
		.clk_1x (clk_1x),
		.rst_n  (rst_n),
		.ioctl  (ioctl),
		.pif_wr (pif_wr)
	);

	cart_loader #(
		.CART_N64_BASE (CART_N64_BASE),
		.CART_GB_BASE  (CART_GB_BASE)
	) u_cart_loader (
		.clk_1x      (clk_1x),
		.rst_n       (rst_n),
		.ioctl       (ioctl),
		.ram_ready   (ram_ready),
		.ram_wr      (ram_wr),
		.ioctl_wait  (ioctl_wait),
		.cart_loaded (cart_loaded),
		.cart_busy   (cart_busy)
	);

	// ====================
	// video and pads
	// ====================
	aspect_ratio_sel u_aspect_ratio_sel (
		.clk_1x (clk_1x),
		.rst_n  (rst_n),
		.cfg    (video_cfg),
		.aspect (aspect)
	);

	pad_port_mux u_pad_port_mux (
		.clk_1x    (clk_1x),
		.rst_n     (rst_n),
		.snac_en   (snac_en),
		.pad_index (pad_index),
		.pad_tx    (pad_tx),
		.user_in   (user_in),
		.user_out  (user_out),
		.pad_rx    (pad_rx)
	);

endmodule

/* include/tb_n64_glue_model.svh */
// n64 glue reference model: expected loader words, addresses, aspect ratios and pad pins
`ifndef TB_N64_GLUE_MODEL_SVH
`define TB_N64_GLUE_MODEL_SVH

// end the run at the first error
task automatic stop_run();
	$display(">>> FAIL");
	$fatal(1, "simulation stopped at first error");
endtask

// single compare point, values shown in hex
task automatic compare_hex(input string name, input logic [63:0] got, input logic [63:0] exp);
	if (got !== exp) begin
		$display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
		stop_run();
	end
endtask

// ====================
// download words
// ====================

// first half in the low halfword
function automatic logic [31:0] cart_word(input logic [15:0] first, input logic [15:0] second);
	return {second, first};
endfunction

// base of the cart type, wraps at 27 bits
function automatic logic [26:0] cart_addr(input logic [26:0] base, input logic [26:0] addr);
	return base + addr;
endfunction

// each halfword swapped, first half on top
function automatic logic [31:0] pif_word(input logic [15:0] first, input logic [15:0] second);
	return {first[7:0], first[15:8], second[7:0], second[15:8]};
endfunction

function automatic logic [9:0] pif_addr(input logic bit6, input logic [26:0] addr);
	return {bit6, addr[10:2]};
endfunction

// ====================
// video
// ====================

// ratio from standard and crop, crop 3 keeps prev
function automatic n64_glue_pkg::aspect_t core_ratio(input n64_glue_pkg::video_cfg_t cfg,
	input n64_glue_pkg::aspect_t prev);
	n64_glue_pkg::aspect_t r;
	r = prev;
	if (cfg.blanks_off) begin
		r = '{arx: 13'd4, ary: 13'd3};
	end else begin
		case ({cfg.is_pal, cfg.crop})
			3'b100: r = '{arx: 13'd512, ary: 13'd387};
			3'b101: r = '{arx: 13'd1024, ary: 13'd731};
			3'b110: r = '{arx: 13'd2048, ary: 13'd1419};
			3'b000: r = '{arx: 13'd512, ary: 13'd381};
			3'b001: r = '{arx: 13'd1280, ary: 13'd889};
			3'b010: r = '{arx: 13'd2560, ary: 13'd1714};
			default: r = prev;
		endcase
	end
	return r;
endfunction

// forced modes override the table
function automatic n64_glue_pkg::aspect_t shown_ratio(input n64_glue_pkg::video_cfg_t cfg,
	input n64_glue_pkg::aspect_t core);
	n64_glue_pkg::aspect_t r;
	r = core;
	if (cfg.ar_mode != 2'd0) begin
		r.arx = {11'd0, cfg.ar_mode} - 13'd1;
		r.ary = 13'd0;
	end
	return r;
endfunction

// ====================
// pads
// ====================

function automatic logic [2:0] pad_pin(input logic [1:0] pad);
	case (pad)
		2'd0: return 3'd1;
		2'd1: return 3'd0;
		2'd2: return 3'd5;
		default: return 3'd4;
	endcase
endfunction

// all pins released except the routed one
function automatic logic [6:0] pad_out(input logic snac, input logic [2:0] pin, input logic tx);
	logic [6:0] v;
	v = 7'h7f;
	if (snac) begin
		v[pin] = tx;
	end
	return v;
endfunction

`endif

/* verification/tb_n64_glue.sv */
// n64 glue testbench: random loader, video and pad stimulus checked against a model
`timescale 1ns/1ns

module tb_n64_glue;

	localparam logic [26:0] N64_BASE = 27'd16777216;
	localparam logic [26:0] GB_BASE  = 27'd8388608;
	localparam int unsigned WORDS    = 20;

	logic                     clk_1x;
	logic                     rst_n;
	n64_glue_pkg::ioctl_req_t ioctl;
	logic                     ram_ready;
	n64_glue_pkg::ram_wr_t    ram_wr;
	logic                     ioctl_wait;
	logic                     cart_loaded;
	logic                     cart_busy;
	n64_glue_pkg::pif_wr_t    pif_wr;
	n64_glue_pkg::video_cfg_t video_cfg;
	n64_glue_pkg::aspect_t    aspect;
	logic                     snac_en;
	logic [1:0]               pad_index;
	logic                     pad_tx;
	logic [6:0]               user_in;
	logic [6:0]               user_out;
	logic                     pad_rx;

	// ram latency table, filled after seeding
	int unsigned ready_delay [0:63];
	int unsigned req_count   = 0;
	int unsigned ready_count = 0;
	// model state
	n64_glue_pkg::aspect_t model_core;
	logic                  model_rx;

	`include "tb_n64_glue_model.svh"

	n64_glue_top #(
		.CART_N64_BASE (N64_BASE),
		.CART_GB_BASE  (GB_BASE)
	) u_dut (
		.clk_1x      (clk_1x),
		.rst_n       (rst_n),
		.ioctl       (ioctl),
		.ram_ready   (ram_ready),
		.ram_wr      (ram_wr),
		.ioctl_wait  (ioctl_wait),
		.cart_loaded (cart_loaded),
		.cart_busy   (cart_busy),
		.pif_wr      (pif_wr),
		.video_cfg   (video_cfg),
		.aspect      (aspect),
		.snac_en     (snac_en),
		.pad_index   (pad_index),
		.pad_tx      (pad_tx),
		.user_in     (user_in),
		.user_out    (user_out),
		.pad_rx      (pad_rx)
	);

	always #5 clk_1x = ~clk_1x;

	// ====================
	// ram responder
	// ====================
	// one ready pulse per request, 1 to 8 cycles later
	always begin
		@(negedge clk_1x);
		if (rst_n && ram_wr.req) begin
			repeat (ready_delay[ready_count % 64]) @(negedge clk_1x);
			ram_ready = 1'b1;
			@(negedge clk_1x);
			ram_ready = 1'b0;
		end
	end

	// every req cycle, also while the responder is busy
	always @(negedge clk_1x) begin
		if (rst_n && ram_wr.req) begin
			req_count++;
		end
	end

	// ready seen by the dut edge
	always @(posedge clk_1x) begin
		if (ram_ready) begin
			ready_count++;
		end
	end

	// ====================
	// host side
	// ====================
	// called on a falling edge, wr high for one cycle
	task automatic host_write(input logic [26:0] addr, input logic [15:0] data);
		ioctl.addr = addr;
		ioctl.dout = data;
		ioctl.wr   = 1'b1;
		@(negedge clk_1x);
		ioctl.wr   = 1'b0;
	endtask

	task automatic cart_download(input logic [5:0] code, input logic [26:0] base);
		logic [31:0] rnd;
		logic [26:0] addr;
		logic [15:0] first;
		logic [15:0] second;
		int unsigned start;
		int unsigned reqs;
		int unsigned cycles;
		int unsigned w;
		ioctl.download = 1'b1;
		ioctl.index    = {2'b00, code};
		@(negedge clk_1x);
		compare_hex("cart_busy", cart_busy, 1'b1);
		for (w = 0; w < WORDS; w++) begin
			rnd    = $urandom;
			addr   = rnd[26:0] & ~27'd3;
			rnd    = $urandom;
			first  = rnd[15:0];
			second = rnd[31:16];
			start  = ready_count;
			reqs   = req_count;
			host_write(addr, first);
			// no stall on the first half
			compare_hex("ioctl_wait", ioctl_wait, 1'b0);
			host_write(addr | 27'd2, second);
			compare_hex("ram_wr.req", ram_wr.req, 1'b1);
			compare_hex("ram_wr.addr", ram_wr.addr, cart_addr(base, addr));
			compare_hex("ram_wr.data", ram_wr.data, cart_word(first, second));
			// host stalled until the ram answers
			cycles = 0;
			while (ready_count == start) begin
				compare_hex("ioctl_wait", ioctl_wait, 1'b1);
				@(negedge clk_1x);
				cycles++;
				if (cycles > 20) begin
					$display("no ram_ready within 20 cycles of a cart request");
					stop_run();
				end
			end
			cycles = 0;
			while (ioctl_wait) begin
				@(negedge clk_1x);
				cycles++;
				if (cycles > 2) begin
					$display("ioctl_wait still high 2 cycles after ram_ready");
					stop_run();
				end
			end
			compare_hex("ram_wr.req count", req_count - reqs, 1);
		end
		ioctl.download = 1'b0;
		repeat (2) @(negedge clk_1x);
		compare_hex("cart_busy", cart_busy, 1'b0);
	endtask

	task automatic pif_download(input int unsigned words);
		logic [31:0] rnd;
		logic [26:0] addr;
		logic [15:0] first;
		logic [15:0] second;
		int unsigned reqs;
		int unsigned w;
		reqs           = req_count;
		ioctl.download = 1'b1;
		ioctl.index    = {2'b00, n64_glue_pkg::INDEX_PIF};
		@(negedge clk_1x);
		for (w = 0; w < words; w++) begin
			rnd    = $urandom;
			addr   = rnd[26:0] & ~27'd3;
			rnd    = $urandom;
			first  = rnd[15:0];
			second = rnd[31:16];
			// upper rom half from index bit 6
			rnd            = $urandom;
			ioctl.index[6] = rnd[0];
			host_write(addr, first);
			host_write(addr | 27'd2, second);
			compare_hex("pif_wr.en", pif_wr.en, 1'b1);
			compare_hex("pif_wr.addr", pif_wr.addr, pif_addr(rnd[0], addr));
			compare_hex("pif_wr.data", pif_wr.data, pif_word(first, second));
			@(negedge clk_1x);
			compare_hex("pif_wr.en", pif_wr.en, 1'b0);
		end
		ioctl.download = 1'b0;
		ioctl.index    = 8'd0;
		@(negedge clk_1x);
		compare_hex("ram_wr.req count", req_count - reqs, 0);
	endtask

	// ====================
	// video and pads
	// ====================
	task automatic aspect_sweep();
		logic [31:0]              rnd;
		n64_glue_pkg::video_cfg_t cfg;
		int unsigned              i;
		// cfg was zero since reset
		model_core = core_ratio(video_cfg, '{arx: 13'd4, ary: 13'd3});
		for (i = 0; i < 30; i++) begin
			rnd = $urandom;
			cfg = rnd[5:0];
			// visible crop 3 hold
			if (i % 6 == 2) begin
				cfg.crop       = 2'd3;
				cfg.blanks_off = 1'b0;
				cfg.ar_mode    = 2'd0;
			end
			video_cfg  = cfg;
			model_core = core_ratio(cfg, model_core);
			@(negedge clk_1x);
			compare_hex("aspect", aspect, shown_ratio(cfg, model_core));
			repeat (2) @(negedge clk_1x);
		end
	endtask

	task automatic pad_sweep();
		logic [31:0] rnd;
		logic [2:0]  pin;
		int unsigned i;
		// snac off so far, rx still at reset value
		model_rx = 1'b1;
		for (i = 0; i < 40; i++) begin
			rnd       = $urandom;
			snac_en   = rnd[0];
			pad_index = rnd[2:1];
			pad_tx    = rnd[3];
			user_in   = rnd[10:4];
			pin       = pad_pin(rnd[2:1]);
			if (rnd[0]) begin
				model_rx = rnd[4 + pin];
			end
			repeat (2) @(negedge clk_1x);
			compare_hex("user_out", user_out, pad_out(rnd[0], pin, rnd[3]));
			compare_hex("pad_rx", pad_rx, model_rx);
		end
	endtask

	// ====================
	// main sequence
	// ====================
	initial begin
		int unsigned i;
		void'($urandom(41281));
		clk_1x    = 1'b0;
		rst_n     = 1'b0;
		ioctl     = '0;
		ram_ready = 1'b0;
		video_cfg = '0;
		snac_en   = 1'b0;
		pad_index = 2'd0;
		pad_tx    = 1'b1;
		user_in   = 7'h7f;
		for (i = 0; i < 64; i++) begin
			ready_delay[i] = 1 + ($urandom % 8);
		end
		repeat (4) @(negedge clk_1x);
		// reset values
		compare_hex("pif_wr.en", pif_wr.en, 1'b0);
		compare_hex("ram_wr.req", ram_wr.req, 1'b0);
		compare_hex("ioctl_wait", ioctl_wait, 1'b0);
		compare_hex("cart_loaded", cart_loaded, 1'b0);
		compare_hex("cart_busy", cart_busy, 1'b0);
		compare_hex("user_out", user_out, 7'h7f);
		compare_hex("aspect", aspect, {13'd4, 13'd3});
		rst_n = 1'b1;
		@(negedge clk_1x);
		// gb alone leaves the loaded flag clear
		cart_download(n64_glue_pkg::INDEX_CART_GB, GB_BASE);
		compare_hex("cart_loaded", cart_loaded, 1'b0);
		cart_download(n64_glue_pkg::INDEX_CART_N64, N64_BASE);
		compare_hex("cart_loaded", cart_loaded, 1'b1);
		pif_download(16);
		aspect_sweep();
		pad_sweep();
		$display(">>> PASS");
		$finish;
	end

endmodule

/* all.f */
+incdir+include
design/n64_glue_pkg.sv
design/pif_rom_loader.sv
design/cart_loader.sv
design/aspect_ratio_sel.sv
design/pad_port_mux.sv
design/n64_glue_top.sv
verification/tb_n64_glue.sv

/* Bender.yml */
package:
  name: n64_glue

sources:
  - files:
      - design/n64_glue_pkg.sv
      - design/pif_rom_loader.sv
      - design/cart_loader.sv
      - design/aspect_ratio_sel.sv
      - design/pad_port_mux.sv
      - design/n64_glue_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/tb_n64_glue.sv
